// File: include/data_mem_settings.svh
////////////////////////////////////////
// data memory model settings
// address map, region depths and datapath widths
////////////////////////////////////////

`ifndef DATA_MEM_SETTINGS_SVH
`define DATA_MEM_SETTINGS_SVH

// datapath widths, tag bit on top of the data word
`define DATA_W        65
`define HALF_W        32
`define BE_W          4
`define WADDR_W       30

// region depths as log2 of the word count
`define DRAM_IDX_W    10
`define TSRAM_IDX_W   8
`define MMREG_OFF_W   8

// widest local index, one extra bit selects the dram half
`define IDX_W         (`DRAM_IDX_W + 1)

// region base byte addresses
`define DRAM_BASE     32'h8000_0000
`define TSRAM_BASE    32'h8300_0000
`define MMREG_BASE    32'h8380_0000

// readback of an unused register offset
`define MMREG_DEFAULT 32'hdead_beef

`endif

// File: design/data_mem_pkg.sv
////////////////////////////////////////
// data memory model package
// request and response structs
// opcode, region and register offset enums
////////////////////////////////////////

`include "data_mem_settings.svh"

package data_mem_pkg;

  ////////////////////////////////////////
  // enums
  ////////////////////////////////////////

  // atomic access kind
  typedef enum logic [1:0] {
    AMO_NONE = 2'd0,
    AMO_LR   = 2'd1,
    AMO_SC   = 2'd2
  } amo_e;

  // decoded target of a request
  typedef enum logic [1:0] {
    REG_NONE  = 2'd0,
    REG_DRAM  = 2'd1,
    REG_TSRAM = 2'd2,
    REG_MMREG = 2'd3
  } region_e;

  // register word offsets inside the mmreg window
  typedef enum logic [`MMREG_OFF_W-1:0] {
    OFF_SCRATCH0 = 8'h00,
    OFF_SCRATCH1 = 8'h01,
    OFF_ERR_EN   = 8'h40,
    OFF_INTR_ACK = 8'h41,
    OFF_DEBUG    = 8'h50
  } mmreg_off_e;

  ////////////////////////////////////////
  // structs
  ////////////////////////////////////////

  typedef struct packed {
    logic                 we;
    logic [`BE_W-1:0]     be;
    logic                 is_cap;
    amo_e                 amo;
    logic [`WADDR_W-1:0]  addr;     // word address, byte bits 31:2
    logic [`DATA_W-1:0]   wdata;
  } mem_req_t;

  typedef struct packed {
    logic [`DATA_W-1:0]   rdata;
    logic                 err;
    logic                 sc_fail;
  } mem_rsp_t;

endpackage

// File: design/req_decode.sv
////////////////////////////////////////
// request address decoder
// region select and local word index
////////////////////////////////////////

`include "data_mem_settings.svh"

module req_decode (
  input  data_mem_pkg::mem_req_t req,
  input  logic                   data_req,
  output data_mem_pkg::region_e  region,
  output logic [`IDX_W-1:0]      word_idx
);

  import data_mem_pkg::*;

  localparam logic [31:0] DRAM_B  = `DRAM_BASE;
  localparam logic [31:0] TSRAM_B = `TSRAM_BASE;
  localparam logic [31:0] MMREG_B = `MMREG_BASE;

  logic dram_hit;
  logic tsram_hit;
  logic mmreg_hit;

  // every bit above the index range has to match the base,
  // so no region shows up twice in the map
  assign dram_hit  = (req.addr[`WADDR_W-1:`IDX_W] == DRAM_B[31:`IDX_W+2]);
  assign tsram_hit = (req.addr[`WADDR_W-1:`TSRAM_IDX_W] == TSRAM_B[31:`TSRAM_IDX_W+2]);
  assign mmreg_hit = (req.addr[`WADDR_W-1:`MMREG_OFF_W] == MMREG_B[31:`MMREG_OFF_W+2]);

  // low word bits, each target slices what it needs
  assign word_idx = req.addr[`IDX_W-1:0];

  always_comb begin
    region = REG_NONE;
    if (data_req) begin
      if (dram_hit) begin
        region = REG_DRAM;
      end else if (tsram_hit) begin
        region = REG_TSRAM;
      end else if (mmreg_hit) begin
        region = REG_MMREG;
      end
    end
  end

  // idle cycles never select a target
  always_comb begin
    a_idle_region : assert final (data_req || (region == REG_NONE))
      else $error("region selected without a request strobe");
  end

endmodule

// File: design/dram_bank.sv
////////////////////////////////////////
// dram bank of 65-bit capability words
// half-word and capability access, lr/sc reservation
////////////////////////////////////////

`include "data_mem_settings.svh"

module dram_bank (
  input  logic                   clk,
  input  logic                   rst_n,
  input  data_mem_pkg::mem_req_t req,
  input  data_mem_pkg::region_e  region,
  input  logic [`IDX_W-1:0]      word_idx,
  output logic [`DATA_W-1:0]     rdata,
  output logic                   sc_fail
);

  import data_mem_pkg::*;

  logic [`DATA_W-1:0]     mem [2**`DRAM_IDX_W];
  logic [`DRAM_IDX_W-1:0] entry;
  logic [5:0]             half_base;
  logic                   hi_half;
  logic                   access;
  logic                   is_sc;
  logic                   rd_en;
  logic                   wr_en;
  logic                   resv_q;

  assign entry     = word_idx[`IDX_W-1:1];
  assign hi_half   = word_idx[0];
  assign half_base = {hi_half, 5'b0_0000};

  assign access = (region == REG_DRAM);
  assign is_sc  = (req.amo == AMO_SC);
  assign rd_en  = access & ~req.we;
  // a store-conditional only lands while the reservation holds
  assign wr_en  = access & req.we & (~is_sc | resv_q);

  ////////////////////////////////////////
  // write port
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr_en) begin
      if (req.is_cap) begin
        mem[entry] <= req.wdata;
      end else begin
        for (int b = 0; b < `BE_W; b++) begin
          if (req.be[b]) begin
            mem[entry][half_base + 8*b +: 8] <= req.wdata[8*b +: 8];
          end
        end
        // tag bit always comes from the cpu
        mem[entry][`DATA_W-1] <= req.wdata[`DATA_W-1];
      end
    end
  end

  ////////////////////////////////////////
  // read port
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rd_en) begin
      if (req.is_cap) begin
        rdata <= mem[entry];
      end else if (hi_half) begin
        rdata <= {{(`DATA_W-`HALF_W){1'b0}}, mem[entry][2*`HALF_W-1:`HALF_W]};
      end else begin
        rdata <= {{(`DATA_W-`HALF_W){1'b0}}, mem[entry][`HALF_W-1:0]};
      end
    end else if (access) begin
      // write responses carry no data
      rdata <= '0;
    end
  end

  // reservation, dropped by any dram store incl. a failed sc
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resv_q  <= 1'b0;
      sc_fail <= 1'b0;
    end else begin
      sc_fail <= access & is_sc & ~resv_q;
      if (access & req.we) begin
        resv_q <= 1'b0;
      end else if (rd_en & (req.amo == AMO_LR)) begin
        resv_q <= 1'b1;
      end
    end
  end

  // sc is a store by definition
  a_sc_is_write : assert property (
    @(posedge clk) disable iff (!rst_n)
    (access && is_sc) |-> req.we
  ) else $error("store-conditional issued as a read");

endmodule

// File: design/tag_sram.sv
////////////////////////////////////////
// tag sram, 32-bit words cleared on reset
// byte-write data port and read-only lookup port
////////////////////////////////////////

`include "data_mem_settings.svh"

module tag_sram (
  input  logic                    clk,
  input  logic                    rst_n,
  input  data_mem_pkg::mem_req_t  req,
  input  data_mem_pkg::region_e   region,
  input  logic [`IDX_W-1:0]       word_idx,
  input  logic                    tsmap_cs,
  input  logic [`TSRAM_IDX_W-1:0] tsmap_addr,
  output logic [`HALF_W-1:0]      rdata,
  output logic [`HALF_W-1:0]      tsmap_rdata
);

  import data_mem_pkg::*;

  logic [`HALF_W-1:0]      mem [2**`TSRAM_IDX_W];
  logic [`TSRAM_IDX_W-1:0] idx;
  logic                    access;
  logic                    wr_en;

  assign idx    = word_idx[`TSRAM_IDX_W-1:0];
  assign access = (region == REG_TSRAM);
  assign wr_en  = access & req.we;

  // port 0 writes and port 1 lookup, whole array starts at zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**`TSRAM_IDX_W; i++) begin
        mem[i] <= '0;
      end
      tsmap_rdata <= '0;
    end else begin
      if (wr_en) begin
        for (int b = 0; b < `BE_W; b++) begin
          if (req.be[b]) begin
            mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
          end
        end
      end
      tsmap_rdata <= tsmap_cs ? mem[tsmap_addr] : '0;
    end
  end

  // port 0 read data
  always_ff @(posedge clk) begin
    if (access) begin
      rdata <= req.we ? '0 : mem[idx];
    end
  end

endmodule

// File: design/mmreg_block.sv
////////////////////////////////////////
// memory-mapped registers
// scratch, error enable, interrupt ack, debug request
////////////////////////////////////////

`include "data_mem_settings.svh"

module mmreg_block (
  input  logic                   clk,
  input  logic                   rst_n,
  input  data_mem_pkg::mem_req_t req,
  input  data_mem_pkg::region_e  region,
  input  logic [`IDX_W-1:0]      word_idx,
  output logic [`HALF_W-1:0]     rdata,
  output logic [3:0]             err_enable_vec,
  output logic [2:0]             intr_ack,
  output logic                   debug_req
);

  import data_mem_pkg::*;

  mmreg_off_e         off;
  logic               access;
  logic               wr_en;
  logic               ack_wr;
  logic [`HALF_W-1:0] scratch0;
  logic [`HALF_W-1:0] scratch1;
  logic [7:0]         dbg_req_cnt;
  logic [7:0]         dbg_ack_cnt;

  assign off    = mmreg_off_e'(word_idx[`MMREG_OFF_W-1:0]);
  assign access = (region == REG_MMREG);
  assign wr_en  = access & req.we;
  assign ack_wr = wr_en & (off == OFF_INTR_ACK);

  ////////////////////////////////////////
  // register writes
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      scratch0       <= '0;
      scratch1       <= '0;
      err_enable_vec <= '0;
      intr_ack       <= '0;
      debug_req      <= 1'b0;
      dbg_req_cnt    <= '0;
      dbg_ack_cnt    <= '0;
    end else begin
      // single-cycle pulse unless written again
      intr_ack <= ack_wr ? req.wdata[2:0] : 3'b000;
      if (wr_en) begin
        case (off)
          OFF_SCRATCH0: scratch0 <= req.wdata[`HALF_W-1:0];
          OFF_SCRATCH1: scratch1 <= req.wdata[`HALF_W-1:0];
          OFF_ERR_EN:   err_enable_vec <= req.wdata[3:0];
          OFF_DEBUG: begin
            debug_req <= req.wdata[0];
            if (req.wdata[0]) begin
              dbg_req_cnt <= dbg_req_cnt + 8'd1;
            end else begin
              dbg_ack_cnt <= dbg_ack_cnt + 8'd1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // readback, sampled with the request
  always_ff @(posedge clk) begin
    if (access) begin
      if (req.we) begin
        rdata <= '0;
      end else begin
        case (off)
          OFF_SCRATCH0: rdata <= scratch0;
          OFF_SCRATCH1: rdata <= scratch1;
          OFF_ERR_EN:   rdata <= {{(`HALF_W-4){1'b0}}, err_enable_vec};
          OFF_DEBUG:    rdata <= {dbg_req_cnt, dbg_ack_cnt, 16'h0000};
          default:      rdata <= `MMREG_DEFAULT;
        endcase
      end
    end
  end

  a_intr_ack_pulse : assert property (
    @(posedge clk) disable iff (!rst_n)
    ((|intr_ack) && !ack_wr) |=> (intr_ack == 3'b000)
  ) else $error("intr_ack held past its pulse");

endmodule

// File: design/resp_merge.sv
////////////////////////////////////////
// response side
// strobe delay, read data select, error and sc status
////////////////////////////////////////

`include "data_mem_settings.svh"

module resp_merge (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  data_req,
  input  data_mem_pkg::region_e region,
  input  logic [`DATA_W-1:0]    dram_rdata,
  input  logic [`HALF_W-1:0]    tsram_rdata,
  input  logic [`HALF_W-1:0]    mmreg_rdata,
  input  logic                  sc_fail,
  output logic                  data_rvalid,
  output data_mem_pkg::mem_rsp_t data_rsp
);

  import data_mem_pkg::*;

  region_e region_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_rvalid <= 1'b0;
      region_q    <= REG_NONE;
    end else begin
      data_rvalid <= data_req;
      region_q    <= region;
    end
  end

  always_comb begin
    data_rsp = '0;
    case (region_q)
      REG_DRAM: begin
        data_rsp.rdata   = dram_rdata;
        data_rsp.sc_fail = sc_fail;
      end
      REG_TSRAM: data_rsp.rdata = {{(`DATA_W-`HALF_W){1'b0}}, tsram_rdata};
      REG_MMREG: data_rsp.rdata = {{(`DATA_W-`HALF_W){1'b0}}, mmreg_rdata};
      // unmapped, data stays zero
      default:   data_rsp.err = data_rvalid;
    endcase
  end

  a_rvalid_follows : assert property (
    @(posedge clk) disable iff (!rst_n)
    (data_req |=> data_rvalid) and (!data_req |=> !data_rvalid)
  ) else $error("data_rvalid out of step with data_req");

endmodule

// File: design/data_mem_top.sv
////////////////////////////////////////
// data memory model top level
////////////////////////////////////////

`include "data_mem_settings.svh"

module data_mem_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    data_req,
  input  data_mem_pkg::mem_req_t  data_req_info,
  input  logic                    tsmap_cs,
  input  logic [`TSRAM_IDX_W-1:0] tsmap_addr,
  output logic                    data_rvalid,
  output data_mem_pkg::mem_rsp_t  data_rsp,
  output logic [`HALF_W-1:0]      tsmap_rdata,
  output logic [3:0]              err_enable_vec,
  output logic [2:0]              intr_ack,
  output logic                    debug_req
);

  import data_mem_pkg::*;

  region_e             region;
  logic [`IDX_W-1:0]   word_idx;
  logic [`DATA_W-1:0]  dram_rdata;
  logic [`HALF_W-1:0]  tsram_rdata;
  logic [`HALF_W-1:0]  mmreg_rdata;
  logic                sc_fail;

  req_decode u_req_decode (
    .req      (data_req_info),
    .data_req (data_req),
    .region   (region),
    .word_idx (word_idx)
  );

  dram_bank u_dram_bank (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (data_req_info),
    .region   (region),
    .word_idx (word_idx),
    .rdata    (dram_rdata),
    .sc_fail  (sc_fail)
  );

  tag_sram u_tag_sram (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (data_req_info),
    .region      (region),
    .word_idx    (word_idx),
    .tsmap_cs    (tsmap_cs),
    .tsmap_addr  (tsmap_addr),
    .rdata       (tsram_rdata),
    .tsmap_rdata (tsmap_rdata)
  );

  mmreg_block u_mmreg_block (
    .clk            (clk),
    .rst_n          (rst_n),
    .req            (data_req_info),
    .region         (region),
    .word_idx       (word_idx),
    .rdata          (mmreg_rdata),
    .err_enable_vec (err_enable_vec),
    .intr_ack       (intr_ack),
    .debug_req      (debug_req)
  );

  resp_merge u_resp_merge (
    .clk         (clk),
    .rst_n       (rst_n),
    .data_req    (data_req),
    .region      (region),
    .dram_rdata  (dram_rdata),
    .tsram_rdata (tsram_rdata),
    .mmreg_rdata (mmreg_rdata),
    .sc_fail     (sc_fail),
    .data_rvalid (data_rvalid),
    .data_rsp    (data_rsp)
  );

endmodule

// File: testbench/tb_ref_pkg.sv
////////////////////////////////////////
// reference model of the data memory
// dram, tag sram, registers, reservation
////////////////////////////////////////

`include "data_mem_settings.svh"

package tb_ref_pkg;

  import data_mem_pkg::*;

  // expected response of one request
  typedef struct packed {
    logic [`DATA_W-1:0] rdata;
    logic               err;
    logic               sc_fail;
    logic               chk_data;   // set for reads and unmapped accesses
  } expect_t;

  // region sizes in bytes
  localparam logic [31:0] DRAM_BYTES  = 32'd1 << (`DRAM_IDX_W + 3);
  localparam logic [31:0] TSRAM_BYTES = 32'd1 << (`TSRAM_IDX_W + 2);
  localparam logic [31:0] MMREG_BYTES = 32'd1 << (`MMREG_OFF_W + 2);

  ////////////////////////////////////////
  // model state
  ////////////////////////////////////////

  logic [`DATA_W-1:0] dram_mem [2**`DRAM_IDX_W];
  logic [`HALF_W-1:0] tag_mem  [2**`TSRAM_IDX_W];
  logic [`HALF_W-1:0] scratch  [2];
  logic [3:0]         exp_err_en;
  logic [2:0]         exp_intr_ack;
  logic               exp_debug_req;
  logic [7:0]         dbg_req_cnt;
  logic [7:0]         dbg_ack_cnt;
  logic               resv;

  function automatic void reset_model();
    foreach (tag_mem[i]) begin
      tag_mem[i] = '0;
    end
    scratch[0]    = '0;
    scratch[1]    = '0;
    exp_err_en    = '0;
    exp_intr_ack  = '0;
    exp_debug_req = 1'b0;
    dbg_req_cnt   = '0;
    dbg_ack_cnt   = '0;
    resv          = 1'b0;
  endfunction

  // lookup port, sampled before any write of the same cycle
  function automatic logic [`HALF_W-1:0] lookup(logic cs, logic [`TSRAM_IDX_W-1:0] a);
    return cs ? tag_mem[a] : '0;
  endfunction

  function automatic logic [`HALF_W-1:0] read_reg(logic [7:0] off);
    case (off)
      OFF_SCRATCH0: return scratch[0];
      OFF_SCRATCH1: return scratch[1];
      OFF_ERR_EN:   return {28'h0, exp_err_en};
      OFF_DEBUG:    return {dbg_req_cnt, dbg_ack_cnt, 16'h0000};
      default:      return `MMREG_DEFAULT;
    endcase
  endfunction

  function automatic void write_reg(logic [7:0] off, logic [`HALF_W-1:0] d);
    case (off)
      OFF_SCRATCH0: scratch[0] = d;
      OFF_SCRATCH1: scratch[1] = d;
      OFF_ERR_EN:   exp_err_en = d[3:0];
      OFF_INTR_ACK: exp_intr_ack = d[2:0];
      OFF_DEBUG: begin
        exp_debug_req = d[0];
        if (d[0]) begin
          dbg_req_cnt = dbg_req_cnt + 8'd1;
        end else begin
          dbg_ack_cnt = dbg_ack_cnt + 8'd1;
        end
      end
      default: ;
    endcase
  endfunction

  ////////////////////////////////////////
  // one request at issue time
  ////////////////////////////////////////

  function automatic expect_t apply(logic req_on, mem_req_t r);
    expect_t     e;
    logic [31:0] byte_addr;
    logic [31:0] idx;
    int          h;
    e = '0;
    // the ack pulse lasts a single cycle
    exp_intr_ack = 3'b000;
    if (!req_on) begin
      return e;
    end
    byte_addr = {r.addr, 2'b00};
    if (byte_addr - `DRAM_BASE < DRAM_BYTES) begin
      idx = (byte_addr - `DRAM_BASE) >> 3;
      h   = byte_addr[2] ? `HALF_W : 0;
      if (r.we) begin
        if (r.amo == AMO_SC) begin
          e.sc_fail = !resv;
        end
        if (r.amo != AMO_SC || resv) begin
          if (r.is_cap) begin
            dram_mem[idx] = r.wdata;
          end else begin
            for (int b = 0; b < `BE_W; b++) begin
              if (r.be[b]) begin
                dram_mem[idx][h + 8*b +: 8] = r.wdata[8*b +: 8];
              end
            end
            dram_mem[idx][`DATA_W-1] = r.wdata[`DATA_W-1];
          end
        end
        resv = 1'b0;
      end else begin
        e.chk_data = 1'b1;
        e.rdata    = r.is_cap ? dram_mem[idx] : `DATA_W'(dram_mem[idx][h +: `HALF_W]);
        if (r.amo == AMO_LR) begin
          resv = 1'b1;
        end
      end
    end else if (byte_addr - `TSRAM_BASE < TSRAM_BYTES) begin
      idx = (byte_addr - `TSRAM_BASE) >> 2;
      if (r.we) begin
        for (int b = 0; b < `BE_W; b++) begin
          if (r.be[b]) begin
            tag_mem[idx][8*b +: 8] = r.wdata[8*b +: 8];
          end
        end
      end else begin
        e.chk_data = 1'b1;
        e.rdata    = `DATA_W'(tag_mem[idx]);
      end
    end else if (byte_addr - `MMREG_BASE < MMREG_BYTES) begin
      idx = (byte_addr - `MMREG_BASE) >> 2;
      if (r.we) begin
        write_reg(idx[7:0], r.wdata[`HALF_W-1:0]);
      end else begin
        e.chk_data = 1'b1;
        e.rdata    = `DATA_W'(read_reg(idx[7:0]));
      end
    end else begin
      // unmapped, zero data and no state change
      e.err      = 1'b1;
      e.chk_data = 1'b1;
    end
    return e;
  endfunction

endpackage

// File: testbench/tb_data_mem.sv
////////////////////////////////////////
// testbench for the data memory model
// random stimulus checked against the reference model
////////////////////////////////////////

`include "data_mem_settings.svh"

module tb_data_mem;

  timeunit 1ns;
  timeprecision 100ps;

  import data_mem_pkg::*;
  import tb_ref_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int DRIVE_DLY  = 10;
  localparam int N_RAND     = 200;
  localparam int N_LRSC     = 40;
  localparam int N_UNMAP    = 60;
  // tag sweep, dram init, random tests, lr/sc, unmapped, final sweep, flushes
  localparam int TOTAL_REQ  = 256 + 4 + 3*N_RAND + 4*N_LRSC + N_UNMAP + 24 + 8;
  localparam int WATCHDOG   = (TOTAL_REQ + 8) * CLK_PERIOD * 2;

  logic                    clk;
  logic                    rst_n;
  logic                    data_req;
  mem_req_t                data_req_info;
  logic                    tsmap_cs;
  logic [`TSRAM_IDX_W-1:0] tsmap_addr;
  logic                    data_rvalid;
  mem_rsp_t                data_rsp;
  logic [`HALF_W-1:0]      tsmap_rdata;
  logic [3:0]              err_enable_vec;
  logic [2:0]              intr_ack;
  logic                    debug_req;

  // small address pools so that hits repeat
  logic [`DRAM_IDX_W-1:0]  dram_pool [4] = '{10'd0, 10'd1, 10'd341, 10'd1023};
  logic [7:0]              tag_pool  [4] = '{8'd0, 8'd3, 8'd127, 8'd255};
  logic [7:0]              reg_pool  [8] = '{8'h00, 8'h01, 8'h40, 8'h41,
                                             8'h50, 8'h02, 8'h7f, 8'hff};
  logic [31:0]             bad_pool  [6] = '{32'h0000_0000, 32'h8000_2000, 32'h8300_0400,
                                             32'h8380_0400, 32'hffff_fffc, 32'h7fff_fffc};

  // response expected at the next edge
  logic                    req_q;
  expect_t                 exp_q;
  logic [`HALF_W-1:0]      tsmap_q;

  int checks;
  int errors;
  int test_checks;
  int test_errors;

  data_mem_top u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req       (data_req),
    .data_req_info  (data_req_info),
    .tsmap_cs       (tsmap_cs),
    .tsmap_addr     (tsmap_addr),
    .data_rvalid    (data_rvalid),
    .data_rsp       (data_rsp),
    .tsmap_rdata    (tsmap_rdata),
    .err_enable_vec (err_enable_vec),
    .intr_ack       (intr_ack),
    .debug_req      (debug_req)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG);
    $display("timeout: tests still running after %0d ns", WATCHDOG);
    $display(">>> FAIL");
    $finish;
  end

  ////////////////////////////////////////
  // request builders
  ////////////////////////////////////////

  function automatic mem_req_t make_req(logic we, logic [3:0] be, logic cap, amo_e amo,
                                        logic [31:0] byte_addr, logic [`DATA_W-1:0] wdata);
    mem_req_t r;
    r.we     = we;
    r.be     = be;
    r.is_cap = cap;
    r.amo    = amo;
    r.addr   = byte_addr[31:2];
    r.wdata  = wdata;
    return r;
  endfunction

  function automatic logic [31:0] dram_byte(logic [`DRAM_IDX_W-1:0] ent, logic hi);
    return `DRAM_BASE + 32'({ent, hi, 2'b00});
  endfunction

  function automatic logic [31:0] tag_byte(logic [7:0] idx);
    return `TSRAM_BASE + 32'({idx, 2'b00});
  endfunction

  function automatic logic [31:0] reg_byte(logic [7:0] off);
    return `MMREG_BASE + 32'({off, 2'b00});
  endfunction

  function automatic logic [`DATA_W-1:0] rand_data();
    logic [95:0] w;
    w = {$urandom(), $urandom(), $urandom()};
    return w[`DATA_W-1:0];
  endfunction

  ////////////////////////////////////////
  // checking and driving
  ////////////////////////////////////////

  task automatic compare(input string name, input logic [`DATA_W-1:0] got,
                         input logic [`DATA_W-1:0] exp);
    checks++;
    test_checks++;
    assert (got === exp) else begin
      errors++;
      test_errors++;
      $display("[ERROR] %0d ns %s: expected %h, got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_outputs();
    compare("data_rvalid", data_rvalid, req_q);
    compare("tsmap_rdata", tsmap_rdata, tsmap_q);
    compare("intr_ack", intr_ack, exp_intr_ack);
    compare("err_enable_vec", err_enable_vec, exp_err_en);
    compare("debug_req", debug_req, exp_debug_req);
    if (req_q) begin
      compare("data_rsp.err", data_rsp.err, exp_q.err);
      compare("data_rsp.sc_fail", data_rsp.sc_fail, exp_q.sc_fail);
      if (exp_q.chk_data) begin
        compare("data_rsp.rdata", data_rsp.rdata, exp_q.rdata);
      end
    end
  endtask

  // check the last response, then issue the next request
  task automatic step(input logic on, input mem_req_t r, input logic cs,
                      input logic [`TSRAM_IDX_W-1:0] ta);
    @(posedge clk);
    #(DRIVE_DLY);
    check_outputs();
    data_req      = on;
    data_req_info = r;
    tsmap_cs      = cs;
    tsmap_addr    = ta;
    tsmap_q       = lookup(cs, ta);
    exp_q         = apply(on, r);
    req_q         = on;
  endtask

  task automatic close_test(input string name);
    step(1'b0, '0, 1'b0, '0);
    $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    mem_req_t    r;
    logic [31:0] a;
    int          kind;
    rst_n         = 1'b0;
    data_req      = 1'b0;
    data_req_info = '0;
    tsmap_cs      = 1'b0;
    tsmap_addr    = '0;
    req_q         = 1'b0;
    exp_q         = '0;
    tsmap_q       = '0;
    checks        = 0;
    errors        = 0;
    test_checks   = 0;
    test_errors   = 0;
    void'($urandom(32'ha1f6_f6dd));
    reset_model();
    repeat (4) @(posedge clk);
    #(DRIVE_DLY);
    rst_n = 1'b1;

    // every tag word reads zero on both ports after reset
    for (int i = 0; i < 2**`TSRAM_IDX_W; i++) begin
      step(1'b1, make_req(0, 0, 0, AMO_NONE, tag_byte(8'(i)), '0), 1'b1, 8'(i));
    end
    close_test("tag_reset");

    foreach (dram_pool[i]) begin
      step(1'b1, make_req(1, 4'hf, 1, AMO_NONE, dram_byte(dram_pool[i], 0), rand_data()),
           1'b0, '0);
    end
    for (int i = 0; i < N_RAND; i++) begin
      a = dram_byte(dram_pool[$urandom % 4], 1'($urandom % 2));
      r = make_req(1'($urandom % 2), 4'($urandom), ($urandom % 4 == 0), AMO_NONE, a,
                   rand_data());
      step(($urandom % 8 != 0), r, 1'($urandom % 2), tag_pool[$urandom % 4]);
    end
    close_test("dram");

    // kind 0 lr then sc, kind 1 sc without lr, kind 2 store between lr and sc
    for (int i = 0; i < N_LRSC; i++) begin
      kind = $urandom % 3;
      a    = dram_byte(dram_pool[$urandom % 4], 1'($urandom % 2));
      if (kind != 1) begin
        step(1'b1, make_req(0, 0, 0, AMO_LR, a, '0), 1'b0, '0);
      end
      if (kind != 0) begin
        r = make_req(1, 4'($urandom), 0, AMO_NONE, dram_byte(dram_pool[$urandom % 4], 1),
                     rand_data());
        step(1'b1, r, 1'b0, '0);
      end
      step(1'b1, make_req(1, 4'($urandom), 1'($urandom % 2), AMO_SC, a, rand_data()),
           1'b0, '0);
      step(1'b1, make_req(0, 0, 1, AMO_NONE, a, '0), 1'b0, '0);
    end
    close_test("lr_sc");

    for (int i = 0; i < N_RAND; i++) begin
      a = tag_byte(tag_pool[$urandom % 4]);
      r = make_req(1'($urandom % 2), 4'($urandom), 0, AMO_NONE, a, rand_data());
      step(($urandom % 8 != 0), r, 1'($urandom % 2), tag_pool[$urandom % 4]);
    end
    close_test("tag_sram");

    for (int i = 0; i < N_RAND; i++) begin
      a = reg_byte(reg_pool[$urandom % 8]);
      r = make_req(1'($urandom % 2), 4'hf, 0, AMO_NONE, a, rand_data());
      step(($urandom % 8 != 0), r, 1'($urandom % 2), tag_pool[$urandom % 4]);
    end
    close_test("registers");

    for (int i = 0; i < N_UNMAP; i++) begin
      r = make_req(1'($urandom % 2), 4'($urandom), 1'($urandom % 2), AMO_NONE,
                   bad_pool[$urandom % 6], rand_data());
      step(1'b1, r, 1'b0, '0);
    end
    close_test("unmapped");

    // reread every pool address to catch stray unmapped stores
    foreach (dram_pool[i]) begin
      step(1'b1, make_req(0, 0, 1, AMO_NONE, dram_byte(dram_pool[i], 0), '0), 1'b0, '0);
      step(1'b1, make_req(0, 0, 0, AMO_NONE, dram_byte(dram_pool[i], 0), '0), 1'b0, '0);
      step(1'b1, make_req(0, 0, 0, AMO_NONE, dram_byte(dram_pool[i], 1), '0), 1'b0, '0);
    end
    foreach (tag_pool[i]) begin
      step(1'b1, make_req(0, 0, 0, AMO_NONE, tag_byte(tag_pool[i]), '0), 1'b1, tag_pool[i]);
    end
    foreach (reg_pool[i]) begin
      step(1'b1, make_req(0, 0, 0, AMO_NONE, reg_byte(reg_pool[i]), '0), 1'b0, '0);
    end
    close_test("sweep");

    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: data_mem.f
+incdir+include
design/data_mem_pkg.sv
design/req_decode.sv
design/dram_bank.sv
design/tag_sram.sv
design/mmreg_block.sv
design/resp_merge.sv
design/data_mem_top.sv
testbench/tb_ref_pkg.sv
testbench/tb_data_mem.sv

// File: Bender.yml
package:
  name: data_mem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/data_mem_pkg.sv
      - design/req_decode.sv
      - design/dram_bank.sv
      - design/tag_sram.sv
      - design/mmreg_block.sv
      - design/resp_merge.sv
      - design/data_mem_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_ref_pkg.sv
      - testbench/tb_data_mem.sv
